/* verilog/cop_cfg.svh */
// Coprocessor result stage configuration for opcode, funct3 codes, credits and memory window
`ifndef COP_CFG_SVH
`define COP_CFG_SVH

// Major opcode of coprocessor instructions (custom-1)
`define COP_OPCODE 7'b0101011

// funct3 selects the instruction class
`define COP_F3_ALU 3'd0
`define COP_F3_LW  3'd1
`define COP_F3_SW  3'd2
`define COP_F3_LH  3'd3
`define COP_F3_SH  3'd4

// Result queue depth, equal to the number of issue credits
`define COP_CREDITS 4

// Inclusive bounds of the legal data address window
`define COP_MEM_LO 32'h0000_1000
`define COP_MEM_HI 32'h0000_FFFF

`endif

/* verilog/cop_pkg.sv */
// Coprocessor result stage types for result codes, instruction classes and vector widths
`include "cop_cfg.svh"

package cop_pkg;

    // Instruction words, rs1 values and effective addresses
    typedef logic [31:0] cop_word_t;

    // Register file address
    typedef logic [4:0] cop_reg_t;

    // Counter wide enough to hold the full credit count
    typedef logic [$clog2(`COP_CREDITS + 1)-1:0] cop_credit_t;

    // Result codes reported for every retired instruction
    // Encoding 7 is not a legal code
    typedef enum logic [2:0] {
        SUCCESS = 3'd0,
        ABORT   = 3'd1,
        BAD_INS = 3'd2,
        BAD_LAD = 3'd3,
        BAD_SAD = 3'd4,
        LD_ERR  = 3'd5,
        ST_ERR  = 3'd6
    } cop_result_e;

    // Instruction class from the decoder
    typedef enum logic [2:0] {
        ALU  = 3'd0,
        LW   = 3'd1,
        SW   = 3'd2,
        LH   = 3'd3,
        SH   = 3'd4,
        NONE = 3'd7
    } cop_class_e;

endpackage

/* verilog/cop_verdict_if.sv */
// Stage-1 verdict bundle from the decoder and address checker to the result selector
`timescale 1ns/1ns

interface cop_verdict_if import cop_pkg::*; ();

    // Decoder fields
    logic       valid;
    cop_class_e ins_class;
    cop_reg_t   rd;
    logic       invalid;

    // Address checker fields
    logic       misaligned;
    logic       out_of_window;

    modport decode (
        output valid,
        output ins_class,
        output rd,
        output invalid
    );

    modport addr (
        output misaligned,
        output out_of_window
    );

    modport sel (
        input valid,
        input ins_class,
        input rd,
        input invalid,
        input misaligned,
        input out_of_window
    );

endinterface

/* verilog/cop_decode.sv */
// Instruction decoder that classifies each issued word and flags invalid encodings
`timescale 1ns/1ns
`include "cop_cfg.svh"

module cop_decode import cop_pkg::*; (
    input  logic            vtx_clk,
    input  logic            arst_n,
    input  logic            issue_valid,
    input  cop_word_t       issue_instr,
    cop_verdict_if.decode   vd
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       dec_invalid;
    cop_class_e dec_class;

    assign opcode = issue_instr[6:0];
    assign funct3 = issue_instr[14:12];

    always_comb begin
        dec_invalid = 1'b0;
        dec_class   = NONE;
        if (opcode != `COP_OPCODE) begin
            dec_invalid = 1'b1;
        end else begin
            case (funct3)
                `COP_F3_ALU: dec_class = ALU;
                `COP_F3_LW:  dec_class = LW;
                `COP_F3_SW:  dec_class = SW;
                `COP_F3_LH:  dec_class = LH;
                `COP_F3_SH:  dec_class = SH;
                // Reserved funct3 values 5 to 7
                default:     dec_invalid = 1'b1;
            endcase
        end
    end

    // One verdict per issue, valid for a single cycle
    always_ff @(posedge vtx_clk or negedge arst_n) begin
        if (!arst_n) begin
            vd.valid <= 1'b0;
        end else begin
            vd.valid <= issue_valid;
        end
    end

    // Verdict payload only loads on an issue
    always_ff @(posedge vtx_clk) begin
        if (issue_valid) begin
            vd.ins_class <= dec_class;
            vd.rd        <= issue_instr[11:7];
            vd.invalid   <= dec_invalid;
        end
    end

    // A valid verdict carries a known class, rd and invalid flag
    assert property (@(posedge vtx_clk) disable iff (!arst_n)
        vd.valid |-> !$isunknown({vd.ins_class, vd.rd, vd.invalid}))
        else $error("decoder verdict has unknown fields");

endmodule

/* verilog/cop_addr_check.sv */
// Address checker that forms rs1 plus immediate and flags alignment and window faults
`timescale 1ns/1ns
`include "cop_cfg.svh"

module cop_addr_check import cop_pkg::*; (
    input  logic          vtx_clk,
    input  logic          arst_n,
    input  logic          issue_valid,
    input  cop_word_t     issue_instr,
    input  cop_word_t     issue_rs1,
    cop_verdict_if.addr   vd
);

    logic [2:0] funct3;
    cop_word_t  imm;
    cop_word_t  eff_addr;
    logic       acc_word;
    logic       acc_half;
    logic       misaligned;
    logic       out_of_window;

    assign funct3 = issue_instr[14:12];

    // Sign-extended 12-bit immediate from bits 31:20
    assign imm      = {{20{issue_instr[31]}}, issue_instr[31:20]};
    assign eff_addr = issue_rs1 + imm;

    // Access width straight from funct3, opcode validity is left to the selector
    assign acc_word = (funct3 == `COP_F3_LW) || (funct3 == `COP_F3_SW);
    assign acc_half = (funct3 == `COP_F3_LH) || (funct3 == `COP_F3_SH);

    assign misaligned = (acc_word && (eff_addr[1:0] != 2'b00)) ||
                        (acc_half && eff_addr[0]);

    assign out_of_window = (acc_word || acc_half) &&
                           ((eff_addr < `COP_MEM_LO) || (eff_addr > `COP_MEM_HI));

    // Registered on the same edge as the decoder verdict
    always_ff @(posedge vtx_clk or negedge arst_n) begin
        if (!arst_n) begin
            vd.misaligned    <= 1'b0;
            vd.out_of_window <= 1'b0;
        end else if (issue_valid) begin
            vd.misaligned    <= misaligned;
            vd.out_of_window <= out_of_window;
        end
    end

endmodule

/* verilog/cop_result_sel.sv */
// Result selector that merges both verdicts into a code and queues it for the consumer
`timescale 1ns/1ns
`include "cop_cfg.svh"

module cop_result_sel import cop_pkg::*; (
    input  logic          vtx_clk,
    input  logic          arst_n,
    cop_verdict_if.sel    vd,
    output logic          result_valid,
    input  logic          result_ready,
    output cop_result_e   result_code,
    output cop_reg_t      result_waddr,
    output logic          result_wen,
    output logic          issue_credit
);

    localparam int DEPTH = `COP_CREDITS;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    cop_result_e      code;
    logic             wen;
    logic             is_load;
    logic             push;
    logic             pop;
    logic             full;
    cop_credit_t      count;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;

    cop_result_e      q_code  [DEPTH];
    cop_reg_t         q_waddr [DEPTH];
    logic             q_wen   [DEPTH];

    assign is_load = (vd.ins_class == LW) || (vd.ins_class == LH);

    // Priority is invalid, then misaligned, then window
    always_comb begin
        code = SUCCESS;
        if (vd.invalid) begin
            code = BAD_INS;
        end else if (vd.ins_class != ALU) begin
            if (vd.misaligned) begin
                code = is_load ? BAD_LAD : BAD_SAD;
            end else if (vd.out_of_window) begin
                code = is_load ? LD_ERR : ST_ERR;
            end
        end
    end

    // Register writeback only for successful ALU and load instructions
    assign wen = (code == SUCCESS) && ((vd.ins_class == ALU) || is_load);

    assign push = vd.valid;
    assign pop  = result_valid && result_ready;
    assign full = (count == cop_credit_t'(DEPTH));

    always_ff @(posedge vtx_clk or negedge arst_n) begin
        if (!arst_n) begin
            count        <= '0;
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            issue_credit <= 1'b0;
        end else begin
            issue_credit <= pop;
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + cop_credit_t'(1);
                2'b01:   count <= count - cop_credit_t'(1);
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge vtx_clk) begin
        if (push) begin
            q_code[wr_ptr]  <= code;
            q_waddr[wr_ptr] <= vd.rd;
            q_wen[wr_ptr]   <= wen;
        end
    end

    assign result_valid = (count != '0);
    assign result_code  = q_code[rd_ptr];
    assign result_waddr = q_waddr[rd_ptr];
    assign result_wen   = q_wen[rd_ptr];

    // Credit accounting by the issuer keeps the queue from overflowing
    assert property (@(posedge vtx_clk) disable iff (!arst_n) push |-> !full)
        else $error("verdict pushed into a full result queue");

    assert property (@(posedge vtx_clk) disable iff (!arst_n)
        result_valid |-> !$isunknown(result_code))
        else $error("unknown result code at the head of the queue");

endmodule

/* verilog/cop_retire_checks.sv */
// Retirement checker that guards result encodings and holds a sticky violation flag
`timescale 1ns/1ns

module cop_retire_checks import cop_pkg::*; (
    input  logic         vtx_clk,
    input  logic         arst_n,
    input  logic         result_valid,
    input  logic         result_ready,
    input  cop_result_e  result_code,
    input  logic         result_wen,
    output logic         check_fail
);

    logic        retire;
    logic        stalled;
    cop_result_e held_code;
    logic        held_wen;
    logic        bad_code;
    logic        bad_wen;
    logic        bad_hold;

    assign retire = result_valid && result_ready;

    // ABORT is legal in general but nothing in this stage produces it
    assign bad_code = retire && ((result_code == ABORT) || (result_code == 3'd7));
    assign bad_wen  = retire && result_wen && (result_code != SUCCESS);

    // A stalled result must stay on the port unchanged
    assign bad_hold = stalled &&
                      (!result_valid || (result_code != held_code) || (result_wen != held_wen));

    always_ff @(posedge vtx_clk or negedge arst_n) begin
        if (!arst_n) begin
            stalled    <= 1'b0;
            check_fail <= 1'b0;
        end else begin
            stalled <= result_valid && !result_ready;
            if (bad_code || bad_wen || bad_hold) begin
                check_fail <= 1'b1;
            end
        end
    end

    always_ff @(posedge vtx_clk) begin
        held_code <= result_code;
        held_wen  <= result_wen;
    end

    assert property (@(posedge vtx_clk) disable iff (!arst_n)
        retire |-> (result_code != ABORT) && (result_code != 3'd7))
        else $error("illegal result code retired");

    assert property (@(posedge vtx_clk) disable iff (!arst_n)
        retire && result_wen |-> (result_code == SUCCESS))
        else $error("register write on a failed instruction");

    assert property (@(posedge vtx_clk) disable iff (!arst_n)
        result_valid && !result_ready |=> result_valid && $stable(result_code)
                                          && $stable(result_wen))
        else $error("result changed while stalled");

endmodule

/* verilog/cop_top.sv */
// Coprocessor instruction result stage top level with credit issue and valid/ready results
`timescale 1ns/1ns

module cop_top import cop_pkg::*; (
    input  logic         vtx_clk,
    input  logic         arst_n,
    input  logic         issue_valid,
    input  cop_word_t    issue_instr,
    input  cop_word_t    issue_rs1,
    output logic         issue_credit,
    output logic         result_valid,
    input  logic         result_ready,
    output cop_result_e  result_code,
    output cop_reg_t     result_waddr,
    output logic         result_wen,
    output logic         check_fail
);

    // Shared verdict of both stage-1 blocks
    cop_verdict_if i_vd ();

    cop_decode i_decode (
        .vtx_clk     (vtx_clk),
        .arst_n      (arst_n),
        .issue_valid (issue_valid),
        .issue_instr (issue_instr),
        .vd          (i_vd.decode)
    );

    cop_addr_check i_addr_check (
        .vtx_clk     (vtx_clk),
        .arst_n      (arst_n),
        .issue_valid (issue_valid),
        .issue_instr (issue_instr),
        .issue_rs1   (issue_rs1),
        .vd          (i_vd.addr)
    );

    cop_result_sel i_result_sel (
        .vtx_clk      (vtx_clk),
        .arst_n       (arst_n),
        .vd           (i_vd.sel),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result_code  (result_code),
        .result_waddr (result_waddr),
        .result_wen   (result_wen),
        .issue_credit (issue_credit)
    );

    cop_retire_checks i_retire_checks (
        .vtx_clk      (vtx_clk),
        .arst_n       (arst_n),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result_code  (result_code),
        .result_wen   (result_wen),
        .check_fail   (check_fail)
    );

endmodule

/* testbench/tb_cop_top.sv */
// Testbench for the coprocessor result stage with credit issue, reference model and assertions
`timescale 1ns/1ns
`include "cop_cfg.svh"

module tb_cop_top import cop_pkg::*; ();

    localparam int MODEL_DEPTH = 512;
    localparam int WAIT_LIMIT  = 200;
    localparam int MIX_COUNT   = 300;

    logic        vtx_clk;
    logic        arst_n;
    logic        issue_valid;
    cop_word_t   issue_instr;
    cop_word_t   issue_rs1;
    logic        issue_credit;
    logic        result_valid;
    logic        result_ready;
    cop_result_e result_code;
    cop_reg_t    result_waddr;
    logic        result_wen;
    logic        check_fail;

    // Reference model, one slot per issued instruction in issue order
    cop_result_e exp_code  [MODEL_DEPTH];
    cop_reg_t    exp_waddr [MODEL_DEPTH];
    logic        exp_wen   [MODEL_DEPTH];
    cop_result_e head_code;
    cop_reg_t    head_waddr;
    logic        head_wen;

    int          issued_cnt;
    int          retire_cnt;
    int          returned_cnt;
    int          credits;
    int          error_cnt;
    int          errs_at_start;
    int          tests_run;
    int          tests_failed;
    logic        timed_out;
    logic        lat_probe;
    logic        stall_probe;
    logic [1:0]  ready_mode;
    logic [31:0] stim_seed;
    logic [31:0] rdy_seed;
    string       test_name;

    cop_top i_dut (
        .vtx_clk      (vtx_clk),
        .arst_n       (arst_n),
        .issue_valid  (issue_valid),
        .issue_instr  (issue_instr),
        .issue_rs1    (issue_rs1),
        .issue_credit (issue_credit),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result_code  (result_code),
        .result_waddr (result_waddr),
        .result_wen   (result_wen),
        .check_fail   (check_fail)
    );

    initial begin
        vtx_clk = 1'b0;
        forever #20 vtx_clk = ~vtx_clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic cop_word_t next_rand();
        stim_seed = xorshift32(stim_seed);
        return stim_seed;
    endfunction

    function automatic cop_word_t build_instr(input logic [6:0] op, input logic [2:0] f3,
                                              input cop_reg_t rd, input logic [11:0] imm,
                                              input logic [4:0] rs1_field);
        return {imm, rs1_field, f3, rd, op};
    endfunction

    // Random address inside the legal window, optionally word aligned
    function automatic cop_word_t window_addr(input logic aligned);
        cop_word_t a;
        a = `COP_MEM_LO + (next_rand() % (`COP_MEM_HI - `COP_MEM_LO + 1));
        if (aligned) begin
            a[1:0] = 2'b00;
        end
        return a;
    endfunction

    // Expected code and write enable straight from the decode and priority rules
    function automatic void expected_result(input cop_word_t instr, input cop_word_t rs1,
                                            output cop_result_e code, output logic wen);
        logic [2:0] f3;
        logic       load;
        logic       word;
        logic       mis;
        cop_word_t  addr;
        f3   = instr[14:12];
        addr = rs1 + {{20{instr[31]}}, instr[31:20]};
        load = (f3 == `COP_F3_LW) || (f3 == `COP_F3_LH);
        word = (f3 == `COP_F3_LW) || (f3 == `COP_F3_SW);
        mis  = word ? (addr[1:0] != 2'b00) : addr[0];
        wen  = 1'b0;
        if ((instr[6:0] != `COP_OPCODE) || (f3 > 3'd4)) begin
            code = BAD_INS;
        end else if (f3 == `COP_F3_ALU) begin
            code = SUCCESS;
            wen  = 1'b1;
        end else if (mis) begin
            code = load ? BAD_LAD : BAD_SAD;
        end else if ((addr < `COP_MEM_LO) || (addr > `COP_MEM_HI)) begin
            code = load ? LD_ERR : ST_ERR;
        end else begin
            code = SUCCESS;
            wen  = load;
        end
    endfunction

    always_comb begin
        head_code  = exp_code[retire_cnt % MODEL_DEPTH];
        head_waddr = exp_waddr[retire_cnt % MODEL_DEPTH];
        head_wen   = exp_wen[retire_cnt % MODEL_DEPTH];
        credits    = `COP_CREDITS - issued_cnt + returned_cnt;
    end

    // Retirements and returned credits counted on the edge that ends each pulse
    always @(posedge vtx_clk or negedge arst_n) begin
        if (!arst_n) begin
            retire_cnt   <= 0;
            returned_cnt <= 0;
        end else begin
            if (result_valid && result_ready) begin
                retire_cnt <= retire_cnt + 1;
            end
            if (issue_credit) begin
                returned_cnt <= returned_cnt + 1;
            end
        end
    end

    always @(negedge vtx_clk) begin
        rdy_seed = xorshift32(rdy_seed);
        case (ready_mode)
            2'd0:    result_ready = 1'b0;
            2'd1:    result_ready = 1'b1;
            default: result_ready = rdy_seed[3] | rdy_seed[9];
        endcase
    end

    assert property (@(posedge vtx_clk) !arst_n |-> !result_valid && !issue_credit && !check_fail)
        else begin
            error_cnt++;
            $display("reset state wrong: result_valid, issue_credit or check_fail is high");
        end

    assert property (@(posedge vtx_clk) disable iff (!arst_n) !check_fail)
        else begin
            error_cnt++;
            $display("%s: the retirement checker raised check_fail", test_name);
        end

    assert property (@(posedge vtx_clk) disable iff (!arst_n)
        result_valid && result_ready |-> retire_cnt < issued_cnt)
        else begin
            error_cnt++;
            $display("%s: a result retired with no instruction outstanding", test_name);
        end

    assert property (@(posedge vtx_clk) disable iff (!arst_n)
        result_valid && result_ready |-> result_code == head_code)
        else begin
            error_cnt++;
            $display("ERR %s result_code expected %0d actual %0d", test_name,
                     $sampled(head_code), $sampled(result_code));
        end

    assert property (@(posedge vtx_clk) disable iff (!arst_n)
        result_valid && result_ready |-> result_waddr == head_waddr)
        else begin
            error_cnt++;
            $display("ERR %s result_waddr expected %0d actual %0d", test_name,
                     $sampled(head_waddr), $sampled(result_waddr));
        end

    assert property (@(posedge vtx_clk) disable iff (!arst_n)
        result_valid && result_ready |-> result_wen == head_wen)
        else begin
            error_cnt++;
            $display("ERR %s result_wen expected %0d actual %0d", test_name,
                     $sampled(head_wen), $sampled(result_wen));
        end

    // One credit pulse per pop, exactly one cycle later
    assert property (@(posedge vtx_clk) disable iff (!arst_n)
        issue_credit == $past(result_valid && result_ready))
        else begin
            error_cnt++;
            $display("%s: issue_credit does not follow a pop by one cycle", test_name);
        end

    assert property (@(posedge vtx_clk) disable iff (!arst_n) credits <= `COP_CREDITS)
        else begin
            error_cnt++;
            $display("%s: more credits came back than were spent", test_name);
        end

    assert property (@(posedge vtx_clk) disable iff (!arst_n)
        lat_probe && $past(issue_valid) |-> !result_valid)
        else begin
            error_cnt++;
            $display("%s: result appeared one cycle after issue", test_name);
        end

    assert property (@(posedge vtx_clk) disable iff (!arst_n)
        lat_probe && $past(issue_valid, 2) |-> result_valid && result_ready)
        else begin
            error_cnt++;
            $display("%s: result did not retire two cycles after issue", test_name);
        end

    assert property (@(posedge vtx_clk) disable iff (!arst_n)
        stall_probe |-> result_valid && !issue_credit && (credits == 0))
        else begin
            error_cnt++;
            $display("%s: full queue under back-pressure returned a credit", test_name);
        end

    task automatic issue_one(input cop_word_t instr, input cop_word_t rs1);
        int          n;
        int          slot;
        cop_result_e code;
        logic        wen;
        n = 0;
        while ((credits == 0) && !timed_out && (n < WAIT_LIMIT)) begin
            @(negedge vtx_clk);
            n++;
        end
        if (credits == 0) begin
            if (!timed_out) begin
                $display("timeout in %s: no issue credit came back", test_name);
            end
            timed_out = 1'b1;
        end else begin
            expected_result(instr, rs1, code, wen);
            slot            = issued_cnt % MODEL_DEPTH;
            exp_code[slot]  = code;
            exp_waddr[slot] = instr[11:7];
            exp_wen[slot]   = wen;
            issue_valid     = 1'b1;
            issue_instr     = instr;
            issue_rs1       = rs1;
            issued_cnt++;
            @(negedge vtx_clk);
            issue_valid = 1'b0;
        end
    endtask

    // Picks rs1 so that rs1 plus the immediate lands on the given address
    task automatic issue_to_addr(input logic [2:0] f3, input cop_word_t addr);
        cop_word_t r;
        cop_word_t rs1;
        r   = next_rand();
        rs1 = addr - {{20{r[31]}}, r[31:20]};
        issue_one(build_instr(`COP_OPCODE, f3, r[11:7], r[31:20], r[19:15]), rs1);
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while ((retire_cnt != issued_cnt) && !timed_out && (n < WAIT_LIMIT)) begin
            @(negedge vtx_clk);
            n++;
        end
        if (retire_cnt != issued_cnt) begin
            if (!timed_out) begin
                $display("timeout in %s: %0d results never retired", test_name,
                         issued_cnt - retire_cnt);
            end
            timed_out = 1'b1;
        end
    endtask

    task automatic set_ready_mode(input logic [1:0] m);
        @(posedge vtx_clk);
        ready_mode = m;
        @(negedge vtx_clk);
    endtask

    task automatic finish_test();
        int errs;
        errs = error_cnt - errs_at_start;
        tests_run++;
        if ((errs != 0) || timed_out) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, errs);
        end else begin
            $display("test %s: ok", test_name);
        end
        errs_at_start = error_cnt;
    endtask

    task automatic lone_alu_latency();
        cop_word_t r;
        cop_word_t rs1;
        test_name = "lone_alu";
        r         = next_rand();
        rs1       = next_rand();
        lat_probe = 1'b1;
        issue_one(build_instr(`COP_OPCODE, `COP_F3_ALU, 5'd17, r[31:20], r[19:15]), rs1);
        wait_drained();
        @(negedge vtx_clk);
        lat_probe = 1'b0;
        finish_test();
    endtask

    task automatic invalid_opcodes();
        int         i;
        cop_word_t  r;
        cop_word_t  rs1;
        logic [6:0] op;
        test_name = "invalid_opcodes";
        for (i = 0; i < 6; i++) begin
            r   = next_rand();
            rs1 = next_rand();
            op  = r[6:0];
            if (op == `COP_OPCODE) begin
                op = op ^ 7'h01;
            end
            issue_one(build_instr(op, r[14:12], r[11:7], r[31:20], r[19:15]), rs1);
        end
        for (i = 5; i < 8; i++) begin
            issue_to_addr(3'(i), window_addr(1'b1));
        end
        // Every legal funct3 must retire with something other than BAD_INS
        for (i = 0; i < 5; i++) begin
            issue_to_addr(3'(i), window_addr(1'b1));
        end
        wait_drained();
        finish_test();
    endtask

    task automatic address_faults();
        test_name = "address_faults";
        issue_to_addr(`COP_F3_LW, window_addr(1'b1) | 32'd2);
        issue_to_addr(`COP_F3_LW, window_addr(1'b1) | 32'd1);
        issue_to_addr(`COP_F3_LH, window_addr(1'b1) | 32'd1);
        issue_to_addr(`COP_F3_SW, window_addr(1'b1) | 32'd3);
        issue_to_addr(`COP_F3_SH, window_addr(1'b1) | 32'd1);
        // Aligned but below or above the window
        issue_to_addr(`COP_F3_LW, 32'h0000_0FFC);
        issue_to_addr(`COP_F3_LH, 32'h0001_0000);
        issue_to_addr(`COP_F3_SW, 32'h8000_0000);
        issue_to_addr(`COP_F3_SH, 32'h0000_0002);
        // Misaligned and outside at once
        issue_to_addr(`COP_F3_LW, 32'h0002_0001);
        issue_to_addr(`COP_F3_SH, 32'h0000_0001);
        issue_to_addr(`COP_F3_LH, 32'h0001_0001);
        wait_drained();
        finish_test();
    endtask

    task automatic queue_backpressure();
        int i;
        test_name = "backpressure";
        set_ready_mode(2'd0);
        for (i = 0; i < `COP_CREDITS; i++) begin
            issue_to_addr(3'(i % 5), window_addr(1'b1));
        end
        repeat (3) @(negedge vtx_clk);
        stall_probe = 1'b1;
        repeat (8) @(negedge vtx_clk);
        stall_probe = 1'b0;
        set_ready_mode(2'd1);
        wait_drained();
        finish_test();
    endtask

    task automatic random_mix();
        int        i;
        cop_word_t r;
        cop_word_t a;
        cop_word_t b;
        test_name = "random_mix";
        set_ready_mode(2'd2);
        for (i = 0; (i < MIX_COUNT) && !timed_out; i++) begin
            r = next_rand();
            a = next_rand();
            b = next_rand();
            case (r[1:0])
                2'd0:    issue_one(a, b);
                2'd1:    issue_to_addr(r[4:2], b);
                default: issue_to_addr(r[4:2], window_addr(r[5]));
            endcase
        end
        wait_drained();
        set_ready_mode(2'd1);
        finish_test();
    endtask

    initial begin
        arst_n        = 1'b0;
        issue_valid   = 1'b0;
        issue_instr   = '0;
        issue_rs1     = '0;
        result_ready  = 1'b1;
        ready_mode    = 2'd1;
        stim_seed     = 32'd42356;
        rdy_seed      = ~32'd42356;
        issued_cnt    = 0;
        error_cnt     = 0;
        errs_at_start = 0;
        tests_run     = 0;
        tests_failed  = 0;
        timed_out     = 1'b0;
        lat_probe     = 1'b0;
        stall_probe   = 1'b0;
        test_name     = "reset";
        repeat (4) @(negedge vtx_clk);
        arst_n = 1'b1;
        @(negedge vtx_clk);

        lone_alu_latency();
        if (!timed_out) begin
            invalid_opcodes();
        end
        if (!timed_out) begin
            address_faults();
        end
        if (!timed_out) begin
            queue_backpressure();
        end
        if (!timed_out) begin
            random_mix();
        end

        $display("summary: %0d tests, %0d failed, %0d errors, %0d results retired",
                 tests_run, tests_failed, error_cnt, retire_cnt);
        if ((error_cnt == 0) && !timed_out) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+verilog
verilog/cop_pkg.sv
verilog/cop_verdict_if.sv
verilog/cop_decode.sv
verilog/cop_addr_check.sv
verilog/cop_result_sel.sv
verilog/cop_retire_checks.sv
verilog/cop_top.sv
testbench/tb_cop_top.sv

/* Makefile */
# Verilator build and run for the coprocessor result stage testbench

VERILATOR ?= verilator
TOP       ?= tb_cop_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'TB PASSED'

clean:
	rm -rf $(BUILD_DIR)
